// ==== all.f ====
rtl/llapi_pkg.sv
rtl/console_pad_pkg.sv
rtl/llapi_pad_decoder.sv
rtl/player_slot_mapper.sv
rtl/llapi_joy_router.sv
tb/llapi_joy_router_sva.sv
tb/llapi_joy_router_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the controller input router testbench

VERILATOR ?= verilator
TOP       ?= llapi_joy_router_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= RESULT: PASS
JOBS      ?= 4
VFLAGS    ?= --timing --assert --timescale 1ns/1ns

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --Mdir $(OBJ_DIR) \
		--top-module $(TOP) -f $(FILELIST)

sim: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/llapi_joy_router_tb.sv ====
//============================================================================
// Table-driven testbench for the controller input router
// Each row is held three cycles, then players and menu_req are compared
//============================================================================
`timescale 1ns/1ns
`default_nettype none

module llapi_joy_router_tb import llapi_pkg::*, console_pad_pkg::*; ();

	localparam int          CLK_HALF  = 20;
	localparam int          STIM_DLY  = 2;
	localparam int          RESET_CYC = 10;
	localparam int          HOLD_CYC  = 3;
	localparam logic [31:0] SEED      = 32'h0dbf_9d1f;
	// Reserved in both views of the report word
	localparam logic [31:0] RSV_MASK  = 32'hf0ff_fc00;

	typedef struct packed {
		logic        rst;
		logic        sel;
		logic        usb_set;
		logic [40:0] pa;
		logic [40:0] pb;
		logic [11:0] exp_a;
		logic [11:0] exp_b;
		// One nibble per slot, slot 0 first: 0-4 USB word, A or B pad, F zero
		logic [19:0] src;
		logic        exp_menu;
	} row_t;

	logic          clk_sys;
	logic          reset;
	logic          llapi_sel;
	llapi_pad_t    pad_a;
	llapi_pad_t    pad_b;
	player_slots_t usb_joy;
	player_slots_t players;
	logic          menu_req;

	row_t          rows[$];
	player_slots_t usb_words[2];
	int            cycles      = 0;
	int            cycle_limit = 0;

	llapi_joy_router uut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.llapi_sel (llapi_sel),
		.pad_a     (pad_a),
		.pad_b     (pad_b),
		.usb_joy   (usb_joy),
		.players   (players),
		.menu_req  (menu_req)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Flags are {rst, sel, usb_set}
	task automatic add_row(input logic [2:0] flags, input logic [40:0] pa,
		input logic [40:0] pb, input logic [11:0] exp_a, input logic [11:0] exp_b,
		input logic [19:0] src, input logic exp_menu);
		rows.push_back({flags, pa, pb, exp_a, exp_b, src, exp_menu});
	endtask

	task automatic fill_usb();
		logic [31:0] rnd;
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < NUM_PLAYERS; i++) begin
				rnd = $urandom();
				// Low nibble keeps all ten words distinct
				usb_words[s][i] = {rnd[11:4], s[0], i[2:0]};
			end
		end
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] noise;
		noise     = $urandom() & RSV_MASK;
		reset     = r.rst;
		llapi_sel = r.sel;
		pad_a     = r.pa | {9'd0, noise};
		pad_b     = r.pb;
		usb_joy   = usb_words[r.usb_set];
	endtask

	function automatic player_slots_t expected_players(input row_t r);
		player_slots_t slots;
		logic [3:0]    code;
		for (int i = 0; i < NUM_PLAYERS; i++) begin
			code = r.src[19-4*i -: 4];
			case (code)
				4'ha:    slots[i] = r.exp_a;
				4'hb:    slots[i] = r.exp_b;
				4'hf:    slots[i] = '0;
				default: slots[i] = usb_words[r.usb_set][code[2:0]];
			endcase
		end
		return slots;
	endfunction

	// ========================================================================
	// Stimulus table
	// ========================================================================
	task automatic build_table();
		add_row(3'b000, 41'h1_01_0000_0003, 41'h1_00_0000_0000,
			12'h000, 12'h000, 20'h01234, 1'b0);
		// Pad B with id NONE or INVALID and nothing pressed is absent
		add_row(3'b010, 41'h1_01_0100_0012, 41'h1_00_0000_0000,
			12'h411, 12'h000, 20'hA0123, 1'b0);
		add_row(3'b011, 41'h1_01_0200_00a8, 41'h1_ff_0000_0000,
			12'ha42, 12'h000, 20'hA0123, 1'b0);
		add_row(3'b010, 41'h1_01_0000_0000, 41'h1_00_0000_0001,
			12'h000, 12'h020, 20'hAB012, 1'b0);
		add_row(3'b011, 41'h1_01_0800_0004, 41'h1_00_0000_0000,
			12'h088, 12'h000, 20'hAB012, 1'b0);
		// Saturn ids 3 and 8
		add_row(3'b010, 41'h0_01_0000_0000, 41'h1_03_0000_0140,
			12'h000, 12'h600, 20'h0B123, 1'b0);
		add_row(3'b011, 41'h0_01_0000_0000, 41'h1_08_0000_02b0,
			12'h000, 12'hb00, 20'h0B123, 1'b0);
		add_row(3'b010, 41'h1_03_0400_030f, 41'h1_01_0000_0040,
			12'h2f4, 12'h100, 20'hAB012, 1'b0);
		add_row(3'b011, 41'h0_01_0000_0000, 41'h0_03_0000_0000,
			12'h000, 12'h000, 20'h01234, 1'b0);
		// Menu combination on each pad, then one bit released
		add_row(3'b010, 41'h1_01_0400_0021, 41'h1_01_0000_0000,
			12'h824, 12'h000, 20'hAB012, 1'b1);
		add_row(3'b011, 41'h1_01_0400_0020, 41'h1_01_0000_0000,
			12'h804, 12'h000, 20'hAB012, 1'b0);
		add_row(3'b010, 41'h0_01_0000_0000, 41'h1_01_0400_0021,
			12'h000, 12'h824, 20'h0B123, 1'b1);
		add_row(3'b011, 41'h0_01_0000_0000, 41'h1_01_0000_0021,
			12'h000, 12'h820, 20'h0B123, 1'b0);
		// Second reset clears the sticky pressed flag of pad B
		add_row(3'b110, 41'h1_01_0000_0001, 41'h1_00_0000_0001,
			12'h000, 12'h000, 20'hFFFFF, 1'b0);
		add_row(3'b010, 41'h1_01_0000_0002, 41'h1_00_0000_0000,
			12'h010, 12'h000, 20'hA0123, 1'b0);
	endtask

	initial begin
		void'($urandom(SEED));
		reset     = 1'b1;
		llapi_sel = 1'b0;
		pad_a     = '0;
		pad_b     = '0;
		usb_joy   = '0;
		fill_usb();
		build_table();
		cycle_limit = RESET_CYC + 4 * rows.size() + 20;
		repeat (RESET_CYC) @(posedge clk_sys);
		#STIM_DLY;
		foreach (rows[n]) begin
			apply_row(rows[n]);
			repeat (HOLD_CYC) @(posedge clk_sys);
			#STIM_DLY;
			compare("players", 64'(players), 64'(expected_players(rows[n])));
			compare("menu_req", 64'(menu_req), 64'(rows[n].exp_menu));
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/llapi_joy_router_sva.sv ====
//============================================================================
// Concurrent checks on the router top level, attached to it with bind
//============================================================================
`timescale 1ns/1ns
`default_nettype none

module llapi_joy_router_sva import llapi_pkg::*, console_pad_pkg::*; (
	input logic          clk_sys,
	input logic          reset,
	input logic          llapi_sel,
	input llapi_pad_t    pad_a,
	input llapi_pad_t    pad_b,
	input player_slots_t usb_joy,
	input player_slots_t players,
	input logic          menu_req
);

	logic combo_in;

	assign combo_in = (pad_a.buttons[LLAPI_BTN_MENU_DOWN] & pad_a.buttons[LLAPI_BTN_START] &
		pad_a.buttons[LLAPI_BTN_B0]) | (pad_b.buttons[LLAPI_BTN_MENU_DOWN] &
		pad_b.buttons[LLAPI_BTN_START] & pad_b.buttons[LLAPI_BTN_B0]);

	reset_clears_outputs: assert property (@(posedge clk_sys)
		reset |=> (players == '0 && !menu_req))
		else $error("players or menu_req not cleared after reset");

	// Decoder and mapper stages, two cycles from pad to menu_req
	menu_follows_combo: assert property (@(posedge clk_sys) disable iff (reset)
		(!$past(reset) && !$past(reset, 2)) |-> (menu_req == $past(combo_in, 2)))
		else $error("menu_req does not follow the menu combination");

	usb_passthrough: assert property (@(posedge clk_sys) disable iff (reset)
		(!$past(reset) && !$past(reset, 2) && !$past(llapi_sel, 2)) |->
		(players == $past(usb_joy)))
		else $error("players differ from usb_joy with LLAPI off");

endmodule

bind llapi_joy_router llapi_joy_router_sva u_sva (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.llapi_sel (llapi_sel),
	.pad_a     (pad_a),
	.pad_b     (pad_b),
	.usb_joy   (usb_joy),
	.players   (players),
	.menu_req  (menu_req)
);

`default_nettype wire

// ==== rtl/llapi_joy_router.sv ====
//============================================================================
// Controller input router top level, two LLAPI decoders and the slot mapper
// Pad inputs reach the outputs in two cycles, USB words in one
//============================================================================
`timescale 1ns/1ns
`default_nettype none

module llapi_joy_router import llapi_pkg::*, console_pad_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          llapi_sel,
	input  llapi_pad_t    pad_a,
	input  llapi_pad_t    pad_b,
	input  player_slots_t usb_joy,
	output player_slots_t players,
	output logic          menu_req
);

	pad_result_t res_a;
	pad_result_t res_b;

	// Port 1 of the user connector
	llapi_pad_decoder u_dec_a (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.llapi_sel (llapi_sel),
		.pad       (pad_a),
		.result    (res_a)
	);

	// Port 2 of the user connector
	llapi_pad_decoder u_dec_b (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.llapi_sel (llapi_sel),
		.pad       (pad_b),
		.result    (res_b)
	);

	player_slot_mapper u_slot_map (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.res_a     (res_a),
		.res_b     (res_b),
		.usb_joy   (usb_joy),
		.players   (players),
		.menu_req  (menu_req)
	);

endmodule

`default_nettype wire

// ==== rtl/player_slot_mapper.sv ====
//============================================================================
// Places decoded LLAPI pads ahead of the USB joysticks in the player slots
// and merges the menu requests, one registered stage
//============================================================================
`timescale 1ns/1ns
`default_nettype none

module player_slot_mapper import console_pad_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  pad_result_t   res_a,
	input  pad_result_t   res_b,
	input  player_slots_t usb_joy,
	output player_slots_t players,
	output logic          menu_req
);

	player_slots_t slots_next;

	// USB joysticks shift down by the number of present pads
	always_comb begin
		case ({res_a.present, res_b.present})
			2'b11: begin
				slots_next[0] = res_a.btn;
				slots_next[1] = res_b.btn;
				for (int i = 2; i < NUM_PLAYERS; i++) begin
					slots_next[i] = usb_joy[i-2];
				end
			end
			2'b10, 2'b01: begin
				// First USB pad fills the slot of the missing one
				slots_next[0] = res_a.present ? res_a.btn : usb_joy[0];
				slots_next[1] = res_b.present ? res_b.btn : usb_joy[0];
				for (int i = 2; i < NUM_PLAYERS; i++) begin
					slots_next[i] = usb_joy[i-1];
				end
			end
			default: begin
				slots_next = usb_joy;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			players  <= '0;
			menu_req <= 1'b0;
		end else begin
			players  <= slots_next;
			menu_req <= res_a.menu_combo | res_b.menu_combo;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/llapi_pad_decoder.sv ====
//============================================================================
// One LLAPI pad: presence detection, button mapping and menu combination
// Result is registered, one cycle from pad to result
//============================================================================
`timescale 1ns/1ns
`default_nettype none

module llapi_pad_decoder import llapi_pkg::*, console_pad_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        llapi_sel,
	input  llapi_pad_t  pad,
	output pad_result_t result
);

	logic          pressed;
	logic          type_known;
	logic          is_saturn;
	logic          present;
	logic          menu_combo;
	llapi_std_t    std_btn;
	llapi_saturn_t sat_btn;
	console_btn_t  btn;

	assign std_btn = pad.buttons.std_view;
	assign sat_btn = pad.buttons.sat_view;

	// ========================================================================
	// Presence
	// ========================================================================

	// Id 0 may be an Atari pad or nothing at all, so wait for a button press
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed <= 1'b0;
		end else if (|pad.buttons) begin
			pressed <= 1'b1;
		end
	end

	assign type_known = (pad.type_id != LLAPI_TYPE_NONE) &&
		(pad.type_id != LLAPI_TYPE_INVALID);
	assign present = pad.en && llapi_sel && (type_known || pressed);

	// ========================================================================
	// Button mapping
	// ========================================================================

	assign is_saturn = (pad.type_id == LLAPI_TYPE_SATURN) ||
		(pad.type_id == LLAPI_TYPE_SATURN_ALT);

	always_comb begin
		// Face buttons, start and d-pad share positions in both views
		btn.start  = std_btn.start;
		btn.select = std_btn.select;
		btn.r      = std_btn.r;
		btn.l      = std_btn.l;
		btn.y      = std_btn.y;
		btn.x      = std_btn.x;
		btn.b      = std_btn.b;
		btn.a      = std_btn.a;
		btn.dpad   = std_btn.dpad;
		if (is_saturn) begin
			// Z stands in for select, shoulders move down one
			btn.select = sat_btn.z;
			btn.l      = sat_btn.c;
			btn.r      = sat_btn.l | sat_btn.r;
		end
	end

	assign menu_combo = pad.buttons[LLAPI_BTN_MENU_DOWN] &
		pad.buttons[LLAPI_BTN_START] & pad.buttons[LLAPI_BTN_B0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			result <= '0;
		end else begin
			result.present    <= present;
			result.menu_combo <= menu_combo;
			result.btn        <= btn;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/console_pad_pkg.sv ====
//============================================================================
// Console side button word, decoded pad result and player slot bundle
//============================================================================
`default_nettype none

package console_pad_pkg;

	localparam int NUM_PLAYERS      = 5;
	localparam int CONSOLE_BTN_BITS = 12;

	// Console button word, start in the top bit
	typedef struct packed {
		logic                        start;
		logic                        select;
		logic                        r;
		logic                        l;
		logic                        y;
		logic                        x;
		logic                        b;
		logic                        a;
		// Eight button bits sit above the d-pad
		logic [CONSOLE_BTN_BITS-9:0] dpad;
	} console_btn_t;

	// Output of one pad decoder
	typedef struct packed {
		logic         present;
		logic         menu_combo;
		console_btn_t btn;
	} pad_result_t;

	// Index 0 is player 1, also the leftmost word
	typedef console_btn_t [0:NUM_PLAYERS-1] player_slots_t;

endpackage

`default_nettype wire

// ==== rtl/llapi_pkg.sv ====
//============================================================================
// LLAPI pad report layout, type ids and menu combination bit positions
// Imported by wildcard into the pad decoder and the top level
//============================================================================
`default_nettype none

package llapi_pkg;

	localparam int LLAPI_BUTTON_BITS = 32;
	localparam int LLAPI_TYPE_BITS   = 8;

	// Controller type ids
	localparam logic [LLAPI_TYPE_BITS-1:0] LLAPI_TYPE_NONE       = 8'd0;
	localparam logic [LLAPI_TYPE_BITS-1:0] LLAPI_TYPE_SATURN     = 8'd3;
	localparam logic [LLAPI_TYPE_BITS-1:0] LLAPI_TYPE_SATURN_ALT = 8'd8;
	localparam logic [LLAPI_TYPE_BITS-1:0] LLAPI_TYPE_INVALID    = 8'd255;

	// Held together these open the on-screen menu
	localparam int LLAPI_BTN_MENU_DOWN = 26;
	localparam int LLAPI_BTN_START     = 5;
	localparam int LLAPI_BTN_B0        = 0;

	// Standard pad view of the report word
	typedef struct packed {
		logic [LLAPI_BUTTON_BITS-29:0] rsv_hi;
		logic [3:0]                    dpad;
		logic [15:0]                   rsv_mid;
		logic                          r;
		logic                          l;
		logic                          start;
		logic                          select;
		logic                          x;
		logic                          y;
		logic                          a;
		logic                          b;
	} llapi_std_t;

	// Saturn pad view, no select button and two extra face buttons
	typedef struct packed {
		logic [LLAPI_BUTTON_BITS-29:0] rsv_hi;
		logic [3:0]                    dpad;
		logic [13:0]                   rsv_mid;
		logic                          r;
		logic                          l;
		logic                          c;
		logic                          z;
		logic                          start;
		logic                          rsv_4;
		logic                          x;
		logic                          y;
		logic                          a;
		logic                          b;
	} llapi_saturn_t;

	typedef union packed {
		llapi_std_t    std_view;
		llapi_saturn_t sat_view;
	} llapi_raw_u;

	// One report as delivered by the LLAPI link
	typedef struct packed {
		logic                       en;
		logic [LLAPI_TYPE_BITS-1:0] type_id;
		llapi_raw_u                 buttons;
	} llapi_pad_t;

endpackage

`default_nettype wire
